// File: bench/cast_checker.sv
`timescale 1ns/1ns

module cast_checker
	import bf16_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic to_int,
	input word_t operand,
	input word_t expected,
	input logic can_accept_cmd,
	input logic data_valid,
	input word_t result,
	output int checks,
	output int errors
);

	// accepted command still waiting for data_valid
	logic pending;
	word_t pend_exp;
	word_t pend_op;
	int want_lat;
	int wait_cycles;
	logic dv_prev;
	word_t held;
	logic after_reset;

	task automatic compare(input string name, input word_t want, input word_t got);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("ERR %s: expected %h, got %h", name, want, got);
		end
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			checks = 0;
			errors = 0;
			pending = 1'b0;
			dv_prev = 1'b0;
			held = '0;
			after_reset = 1'b1;
		end
		else
		begin
			// first cycle out of reset shows the reset state
			if (after_reset)
			begin
				after_reset = 1'b0;
				compare("can_accept_cmd", 64'd1, 64'(can_accept_cmd));
				compare("data_valid", 64'd0, 64'(data_valid));
				compare("result", 64'd0, result);
			end
			if (pending)
			begin
				if (data_valid)
				begin
					pending = 1'b0;
					held = result;
					compare("result", pend_exp, result);
					// ready again together with data_valid
					compare("can_accept_cmd", 64'd1, 64'(can_accept_cmd));
					if (wait_cycles != want_lat)
					begin
						errors++;
						$display("data_valid rose %0d cycles after acceptance instead of %0d",
							wait_cycles, want_lat);
					end
				end
				else if (wait_cycles > 4)
				begin
					errors++;
					pending = 1'b0;
					$display("no data_valid within 5 cycles for operand %h", pend_op);
				end
				else
				begin
					// busy until the result is out
					compare("can_accept_cmd", 64'd0, 64'(can_accept_cmd));
					wait_cycles++;
				end
			end
			else if (data_valid)
			begin
				if (!dv_prev)
				begin
					errors++;
					$display("data_valid rose with no command in flight");
				end
				else if (result !== held)
				begin
					errors++;
					$display("ERR result: held %h, changed to %h", held, result);
				end
			end
			if (start && can_accept_cmd)
			begin
				pending = 1'b1;
				pend_exp = expected;
				pend_op = operand;
				want_lat = to_int ? 2 : 1;
				wait_cycles = 0;
			end
			dv_prev = data_valid;
		end
	end

endmodule

// File: bench/tb_cast.sv
`timescale 1ns/1ns

module tb_cast
	import bf16_pkg::*;
();

	localparam int reset_cycles = 16;
	localparam int n_fixed = 6;
	localparam int n_rand = 8;
	localparam int n_sat = 12;
	localparam int n_pairs = 10;
	// each sweep covers 4 sizes times both signedness settings
	localparam int n_cmds = 8 * (n_fixed + 2 * n_rand + n_sat) + 2 * n_pairs;

	logic clk;
	logic rst_n;
	logic start;
	logic to_int;
	word_t operand;
	type_size_t type_size;
	logic type_signed;
	word_t expected;
	logic can_accept_cmd;
	logic data_valid;
	word_t result;
	int checks;
	int errors;
	int tb_errors;
	int group_checks;
	int group_errors;
	logic [31:0] seed;

	bf16_cast_unit UUT (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.to_int(to_int),
		.operand(operand),
		.type_size(type_size),
		.type_signed(type_signed),
		.can_accept_cmd(can_accept_cmd),
		.data_valid(data_valid),
		.result(result)
	);

	cast_checker u_checker (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.to_int(to_int),
		.operand(operand),
		.expected(expected),
		.can_accept_cmd(can_accept_cmd),
		.data_valid(data_valid),
		.result(result),
		.checks(checks),
		.errors(errors)
	);

	always
	begin
		clk = 1'b0;
		#20;
		clk = 1'b1;
		#20;
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int width_of(input type_size_t sz);
		return 8 << int'(sz);
	endfunction

	function automatic word_t ref_from_int(input word_t op, input type_size_t sz, input logic sgn);
		int w;
		int p;
		word_t mask;
		word_t v;
		word_t mag;
		logic neg;
		bf16_exp_t e;
		logic [6:0] m;
		w = width_of(sz);
		mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
		v = op & mask;
		neg = sgn && v[w - 1];
		mag = neg ? (-v) & mask : v;
		if (mag == '0)
			return '0;
		p = 63;
		while (!mag[p])
			p--;
		e = 8'(127 + p);
		// seven bits below the leading one, rest dropped
		if (p >= 7)
			m = 7'(mag >> (p - 7));
		else
			m = 7'(mag << (7 - p));
		return {48'd0, neg, e, m};
	endfunction

	function automatic word_t ref_to_int(input bf16_t b, input type_size_t sz, input logic sgn);
		int w;
		int unb;
		logic neg;
		logic big;
		word_t mag;
		word_t mask;
		word_t half;
		w = width_of(sz);
		mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
		half = 64'd1 << (w - 1);
		if (b[14:7] == 8'd0)
			return '0;
		// NaN counts as positive
		neg = b[15] && !(b[14:7] == 8'hff && b[6:0] != 7'd0);
		unb = int'(b[14:7]) - 127;
		big = (b[14:7] == 8'hff) || (unb >= 64);
		if (unb < 0)
			mag = '0;
		else if (unb <= 7)
			mag = {56'd0, 1'b1, b[6:0]} >> (7 - unb);
		else
			mag = {56'd0, 1'b1, b[6:0]} << (unb - 7);
		if (sgn)
		begin
			if (!neg && (big || mag > half - 64'd1))
				return half - 64'd1;
			if (neg && (big || mag > half))
				return -half;
			return neg ? -mag : mag;
		end
		if (neg)
			return '0;
		if (big || (w < 64 && mag > mask))
			return mask;
		return mag;
	endfunction

	// edge values around the range of a w-bit target
	function automatic bf16_t sat_case(input int k, input int w);
		bf16_exp_t top;
		top = 8'(127 + w - 1);
		case (k)
		0: return 16'h0000;
		1: return 16'h8000;
		2: return 16'h0001;
		3: return 16'h7f80;
		4: return 16'hff80;
		5: return 16'hffc1;
		6: return {1'b0, top, 7'h01};
		7: return {1'b0, top + 8'd1, 7'h00};
		8: return {1'b1, top, 7'h00};
		9: return {1'b1, top, 7'h01};
		10: return {1'b1, 8'd130, 7'h20};
		default: return {1'b0, 8'd126, 7'h7f};
		endcase
	endfunction

	task automatic next_word(output word_t r);
		logic [31:0] hi;
		seed = lcg(seed);
		hi = seed;
		seed = lcg(seed);
		r = {hi, seed};
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (!can_accept_cmd && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (!can_accept_cmd)
		begin
			tb_errors++;
			$display("can_accept_cmd stayed low for 20 cycles");
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge clk);
		while (!data_valid && n < 10)
		begin
			@(negedge clk);
			n++;
		end
		if (!data_valid)
		begin
			tb_errors++;
			$display("data_valid did not rise within 10 cycles");
		end
		// give the checker one edge to sample the result
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic send_cmd(input logic dir, input word_t op, input type_size_t sz,
		input logic sgn, input logic stray);
		word_t want;
		if (dir)
			want = ref_to_int(op[15:0], sz, sgn);
		else
			want = ref_from_int(op, sz, sgn);
		wait_ready();
		@(posedge clk);
		start <= 1'b1;
		to_int <= dir;
		operand <= op;
		type_size <= sz;
		type_signed <= sgn;
		expected <= want;
		@(posedge clk);
		// stray pulse lands while the unit is busy
		if (stray)
		begin
			operand <= ~op;
			@(posedge clk);
		end
		start <= 1'b0;
		wait_done();
	endtask

	task automatic end_group(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - group_checks,
			errors - group_errors);
		group_checks = checks;
		group_errors = errors;
	endtask

	initial
	begin
		word_t r;
		bf16_t b;
		type_size_t sz;
		logic sgn;
		int w;
		int s;
		int g;
		int k;
		rst_n = 1'b0;
		start = 1'b0;
		to_int = 1'b0;
		operand = '0;
		type_size = sz8;
		type_signed = 1'b0;
		expected = '0;
		tb_errors = 0;
		group_checks = 0;
		group_errors = 0;
		seed = 32'hd24f;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		end_group("reset");

		for (s = 0; s < 4; s++)
		begin
			for (g = 0; g < 2; g++)
			begin
				sz = type_size_t'(s);
				sgn = (g == 1);
				w = width_of(sz);
				next_word(r);
				send_cmd(1'b0, '0, sz, sgn, 1'b0);
				send_cmd(1'b0, 64'd1, sz, sgn, 1'b0);
				send_cmd(1'b0, 64'd1 << (int'(r[63:58]) % w), sz, sgn, 1'b0);
				send_cmd(1'b0, 64'd1 << (w - 1), sz, sgn, 1'b0);
				send_cmd(1'b0, '1, sz, sgn, 1'b0);
				send_cmd(1'b0, (64'd1 << (w - 1)) - 64'd1, sz, sgn, 1'b0);
				for (k = 0; k < n_rand; k++)
				begin
					next_word(r);
					send_cmd(1'b0, r, sz, sgn, 1'b0);
				end
			end
		end
		end_group("int to bf16");

		for (s = 0; s < 4; s++)
		begin
			for (g = 0; g < 2; g++)
			begin
				for (k = 0; k < n_rand; k++)
				begin
					next_word(r);
					// exponents 120 to 190
					b = {r[31], 8'(120 + int'(r[63:48]) % 71), r[30:24]};
					send_cmd(1'b1, {r[63:16], b}, type_size_t'(s), g == 1, 1'b0);
				end
			end
		end
		end_group("bf16 to int");

		for (s = 0; s < 4; s++)
		begin
			for (g = 0; g < 2; g++)
			begin
				w = width_of(type_size_t'(s));
				for (k = 0; k < n_sat; k++)
					send_cmd(1'b1, {48'd0, sat_case(k, w)}, type_size_t'(s), g == 1, 1'b0);
			end
		end
		end_group("saturation");

		for (k = 0; k < n_pairs; k++)
		begin
			next_word(r);
			b = {r[31], 8'(120 + int'(r[63:48]) % 71), r[30:24]};
			send_cmd(1'b1, {r[63:16], b}, type_size_t'(k % 4), r[20], 1'b1);
			repeat (3) @(posedge clk);
			next_word(r);
			send_cmd(1'b0, r, type_size_t'(r[41:40]), r[42], 1'b0);
			repeat (3) @(posedge clk);
		end
		@(negedge clk);
		end_group("flow control");

		$display("total: %0d checks, %0d errors, %0d testbench errors", checks, errors,
			tb_errors);
		if (errors == 0 && tb_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// about 10 cycles per command at worst
	initial
	begin
		repeat (reset_cycles + 4 + n_cmds * 10) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: project.f
rtl/bf16_pkg.sv
rtl/clz64.sv
rtl/bf16_from_int.sv
rtl/bf16_to_int.sv
rtl/bf16_cast_unit.sv
bench/cast_checker.sv
bench/tb_cast.sv

// File: rtl/bf16_cast_unit.sv
`timescale 1ns/1ns

module bf16_cast_unit
	import bf16_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic to_int,
	input word_t operand,
	input type_size_t type_size,
	input logic type_signed,
	output logic can_accept_cmd,
	output logic data_valid,
	output word_t result
);

	logic accept;

	// direction of the last accepted command
	logic dir_q;

	logic fi_start;
	logic fi_ready;
	logic fi_valid;
	bf16_t fi_result;

	logic ti_start;
	logic ti_ready;
	logic ti_valid;
	word_t ti_result;

	// only one command in flight across both converters
	assign accept = start && can_accept_cmd;
	assign fi_start = accept && !to_int;
	assign ti_start = accept && to_int;

	bf16_from_int u_from_int (
		.clk(clk),
		.rst_n(rst_n),
		.start(fi_start),
		.operand(operand),
		.type_size(type_size),
		.type_signed(type_signed),
		.can_accept_cmd(fi_ready),
		.data_valid(fi_valid),
		.result(fi_result)
	);

	bf16_to_int u_to_int (
		.clk(clk),
		.rst_n(rst_n),
		.start(ti_start),
		.operand(operand[15:0]),
		.type_size(type_size),
		.type_signed(type_signed),
		.can_accept_cmd(ti_ready),
		.data_valid(ti_valid),
		.result(ti_result)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			dir_q <= 1'b0;
		else if (accept)
			dir_q <= to_int;
	end

	assign can_accept_cmd = fi_ready && ti_ready;
	assign data_valid = dir_q ? ti_valid : fi_valid;
	assign result = dir_q ? ti_result : {48'd0, fi_result};

endmodule

// File: rtl/bf16_from_int.sv
`timescale 1ns/1ns

module bf16_from_int
	import bf16_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input word_t operand,
	input type_size_t type_size,
	input logic type_signed,
	output logic can_accept_cmd,
	output logic data_valid,
	output bf16_t result
);

	typedef enum logic
	{
		st_idle,
		st_finishing
	} state_t;

	state_t state;

	word_t zext;
	word_t sext;
	word_t mag_next;
	logic neg_next;

	word_t mag_q;
	logic sign_q;

	clz_t lead_zeros;
	word_t norm;
	bf16_exp_t exp_next;

	clz64 u_clz (
		.value(mag_q),
		.count(lead_zeros)
	);

	// narrow to the command width
	always_comb
	begin
		case (type_size)
		sz8:
		begin
			zext = {56'd0, operand[7:0]};
			sext = {{56{operand[7]}}, operand[7:0]};
		end
		sz16:
		begin
			zext = {48'd0, operand[15:0]};
			sext = {{48{operand[15]}}, operand[15:0]};
		end
		sz32:
		begin
			zext = {32'd0, operand[31:0]};
			sext = {{32{operand[31]}}, operand[31:0]};
		end
		default:
		begin
			zext = operand;
			sext = operand;
		end
		endcase

		neg_next = type_signed && sext[63];
		// 2^(w-1) still fits for the most negative value
		mag_next = neg_next ? -sext : zext;
	end

	// leading one moves to bit 63
	assign norm = mag_q << lead_zeros;
	assign exp_next = bf16_bias + 8'd63 - {1'b0, lead_zeros};

	assign can_accept_cmd = (state == st_idle);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			data_valid <= 1'b0;
			result <= '0;
		end
		else
		begin
			case (state)
			st_idle:
			begin
				if (start)
				begin
					state <= st_finishing;
					data_valid <= 1'b0;
				end
			end
			st_finishing:
			begin
				state <= st_idle;
				data_valid <= 1'b1;
				// count of 64 means a zero magnitude
				if (lead_zeros[6])
					result <= '0;
				else
					result <= {sign_q, exp_next, norm[62:56]};
			end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_idle && start)
		begin
			mag_q <= mag_next;
			sign_q <= neg_next;
		end
	end

endmodule

// File: rtl/bf16_pkg.sv
package bf16_pkg;

	// 64-bit integer operand or result
	typedef logic [63:0] word_t;

	// bfloat16: sign 15, exponent 14..7, mantissa 6..0
	typedef logic [15:0] bf16_t;

	// encoded exponent field
	typedef logic [7:0] bf16_exp_t;

	// leading zero count, 0 to 64
	typedef logic [6:0] clz_t;

	// integer width of a command
	typedef enum logic [1:0]
	{
		sz8,
		sz16,
		sz32,
		sz64
	} type_size_t;

	// exponent bias
	localparam bf16_exp_t bf16_bias = 8'd127;

	// exponent for infinity and NaN
	localparam bf16_exp_t bf16_max_exp = 8'd255;

endpackage

// File: rtl/bf16_to_int.sv
`timescale 1ns/1ns

module bf16_to_int
	import bf16_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input bf16_t operand,
	input type_size_t type_size,
	input logic type_signed,
	output logic can_accept_cmd,
	output logic data_valid,
	output word_t result
);

	typedef enum logic [1:0]
	{
		st_idle,
		st_inner,
		st_finishing
	} state_t;

	state_t state;

	bf16_exp_t op_exp;
	logic op_nan;

	// captured command
	logic neg_q;
	logic [6:0] man_q;
	logic signed [8:0] unb_exp_q;
	type_size_t size_q;
	logic signed_q;

	// magnitude stage
	logic signed [8:0] top_bit;
	logic signed [8:0] lsh_full;
	logic [7:0] sig;
	logic [2:0] rshift;
	word_t mag_next;
	word_t mag_q;
	logic ovf_half_q;
	logic ovf_full_q;

	// saturation stage
	word_t lim_mask;
	word_t max_pos;
	word_t min_neg;
	word_t sat_next;

	assign op_exp = operand[14:7];
	assign op_nan = (op_exp == bf16_max_exp) && (operand[6:0] != '0);

	// bit position of the type's top bit, w-1
	always_comb
	begin
		case (size_q)
		sz8: top_bit = 9'sd7;
		sz16: top_bit = 9'sd15;
		sz32: top_bit = 9'sd31;
		default: top_bit = 9'sd63;
		endcase
	end

	// value is sig * 2^(e-7)
	assign sig = {1'b1, man_q};
	assign rshift = 3'd7 - unb_exp_q[2:0];
	assign lsh_full = unb_exp_q - 9'sd7;

	always_comb
	begin
		// also covers exponent 0, e is -127 there
		if (unb_exp_q < 9'sd0)
			mag_next = '0;
		else if (unb_exp_q < 9'sd7)
			mag_next = {56'd0, sig} >> rshift;
		else
			mag_next = {56'd0, sig} << lsh_full[6:0];
	end

	always_comb
	begin
		case (size_q)
		sz8: lim_mask = 64'h0000_0000_0000_00ff;
		sz16: lim_mask = 64'h0000_0000_0000_ffff;
		sz32: lim_mask = 64'h0000_0000_ffff_ffff;
		default: lim_mask = '1;
		endcase

		max_pos = lim_mask >> 1;
		// already sign-extended to 64 bits
		min_neg = ~max_pos;

		if (signed_q)
		begin
			if (!neg_q && ovf_half_q)
				sat_next = max_pos;
			// M of exactly 2^(w-1) is the minimum as well
			else if (neg_q && ovf_half_q)
				sat_next = min_neg;
			else if (neg_q)
				sat_next = -mag_q;
			else
				sat_next = mag_q;
		end
		else
		begin
			if (neg_q)
				sat_next = '0;
			else if (ovf_full_q)
				sat_next = lim_mask;
			else
				sat_next = mag_q;
		end
	end

	assign can_accept_cmd = (state == st_idle);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			data_valid <= 1'b0;
			result <= '0;
		end
		else
		begin
			case (state)
			st_idle:
			begin
				if (start)
				begin
					state <= st_inner;
					data_valid <= 1'b0;
				end
			end
			st_inner:
			begin
				state <= st_finishing;
			end
			default:
			begin
				state <= st_idle;
				data_valid <= 1'b1;
				result <= sat_next;
			end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_idle && start)
		begin
			// NaN saturates as a positive value
			neg_q <= operand[15] && !op_nan;
			man_q <= operand[6:0];
			unb_exp_q <= $signed({1'b0, op_exp}) - $signed({1'b0, bf16_bias});
			size_q <= type_size;
			signed_q <= type_signed;
		end
		if (state == st_inner)
		begin
			mag_q <= mag_next;
			// M >= 2^(w-1), M >= 2^w
			ovf_half_q <= (unb_exp_q >= top_bit);
			ovf_full_q <= (unb_exp_q > top_bit);
		end
	end

endmodule

// File: rtl/clz64.sv
`timescale 1ns/1ns

module clz64
	import bf16_pkg::*;
(
	input word_t value,
	output clz_t count
);

	// one bit of the count per halving step
	logic [5:0] zeros;
	word_t s32;
	word_t s16;
	word_t s8;
	word_t s4;
	word_t s2;

	assign zeros[5] = (value[63:32] == '0);
	assign s32 = zeros[5] ? {value[31:0], 32'd0} : value;

	assign zeros[4] = (s32[63:48] == '0);
	assign s16 = zeros[4] ? {s32[47:0], 16'd0} : s32;

	assign zeros[3] = (s16[63:56] == '0);
	assign s8 = zeros[3] ? {s16[55:0], 8'd0} : s16;

	assign zeros[2] = (s8[63:60] == '0);
	assign s4 = zeros[2] ? {s8[59:0], 4'd0} : s8;

	assign zeros[1] = (s4[63:62] == '0);
	assign s2 = zeros[1] ? {s4[61:0], 2'd0} : s4;

	// last step looks at a single bit
	assign zeros[0] = ~s2[63];

	// the tree reads 63 for an all-zero word
	assign count = (value == '0) ? 7'd64 : {1'b0, zeros};

endmodule

// File: run.sh
#!/bin/sh
# build the bfloat16 cast testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -j 0 --top-module tb_cast -f project.f -o tb_cast_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_cast_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$log"; then
	exit 1
fi
if ! grep -q "Result: PASSED" "$log"; then
	echo "no verdict found in $log"
	exit 1
fi
exit 0
